/* Bender.yml */
package:
  name: nes_io_frontend

sources:
  # shared package first
  - hdl/nes_io_pkg.sv

  # leaf blocks
  - hdl/joypad_serializer.sv
  - hdl/controller_ports.sv
  - hdl/palette_loader.sv
  - hdl/reset_sequencer.sv

  # top level
  - hdl/nes_io_frontend.sv

  # testbench
  - target: simulation
    files:
      - test/tb_nes_io_frontend.sv

# top modules: tb_nes_io_frontend for simulation, nes_io_frontend for synthesis

/* build.f */
hdl/nes_io_pkg.sv
hdl/joypad_serializer.sv
hdl/controller_ports.sv
hdl/palette_loader.sv
hdl/reset_sequencer.sv
hdl/nes_io_frontend.sv
test/tb_nes_io_frontend.sv

/* hdl/controller_ports.sv */
`timescale 1ns/1ps

module controller_ports (
  input  logic                     clk_ppu_21_47,
  input  logic                     reset_nes,
  input  logic                     joypad_latch,
  input  logic [1:0]               joypad_clock,
  input  nes_io_pkg::button_byte_t p1_buttons,
  input  nes_io_pkg::button_byte_t p2_buttons,
  input  nes_io_pkg::button_byte_t p3_buttons,
  input  nes_io_pkg::button_byte_t p4_buttons,
  input  logic                     multitap_enabled,
  input  logic                     swap_controllers,
  input  logic                     p1_data,
  output logic                     joypad1_data,
  output logic                     joypad2_data,
  output logic                     p1_latch,
  output logic                     p1_clk
);

  // player byte presented on each port
  nes_io_pkg::button_byte_t port1_player;
  nes_io_pkg::button_byte_t port2_player;

  // serial bits from the emulated pads
  logic port1_serial;
  logic port2_serial;

  // swap trades players 1 and 2 only, extras stay put
  assign port1_player = swap_controllers ? p2_buttons : p1_buttons;
  assign port2_player = swap_controllers ? p1_buttons : p2_buttons;

  joypad_serializer #(
    .SIGNATURE(nes_io_pkg::PORT1_SIGNATURE)
  ) i_port1 (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .latch           (joypad_latch),
    .port_clock      (joypad_clock[0]),
    .player          (port1_player),
    .extra_player    (p3_buttons),
    .multitap_enabled(multitap_enabled),
    .serial_data     (port1_serial)
  );

  joypad_serializer #(
    .SIGNATURE(nes_io_pkg::PORT2_SIGNATURE)
  ) i_port2 (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .latch           (joypad_latch),
    .port_clock      (joypad_clock[1]),
    .player          (port2_player),
    .extra_player    (p4_buttons),
    .multitap_enabled(multitap_enabled),
    .serial_data     (port2_serial)
  );

  // real pad data is active low, the core wants active high
  assign joypad1_data = port1_serial | ~p1_data;
  assign joypad2_data = port2_serial;

  // physical port 1 follows the core's strobe and clock
  assign p1_latch = joypad_latch;
  assign p1_clk   = ~joypad_clock[0];

endmodule

/* hdl/joypad_serializer.sv */
`timescale 1ns/1ps

module joypad_serializer #(
  parameter nes_io_pkg::button_byte_t SIGNATURE = nes_io_pkg::PORT1_SIGNATURE
) (
  input  logic                     clk_ppu_21_47,
  input  logic                     reset_nes,
  input  logic                     latch,
  input  logic                     port_clock,
  input  nes_io_pkg::button_byte_t player,
  input  nes_io_pkg::button_byte_t extra_player,
  input  logic                     multitap_enabled,
  output logic                     serial_data
);

  // report captured on latch
  nes_io_pkg::port_shift_t report;

  // shift chain, bit 0 is what the core reads
  nes_io_pkg::port_shift_t shift_chain;

  // registered port clock for edge detection
  logic port_clock_q;
  logic port_clock_fall;

  // low byte is always the player on this port
  always_comb begin
    if (multitap_enabled) begin
      report = {SIGNATURE, extra_player, player};
    end else begin
      report = {nes_io_pkg::NO_EXTRA_PLAYERS, player};
    end
  end

  // falling edge seen against the copy from the last cycle
  assign port_clock_fall = port_clock_q && !port_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      port_clock_q <= 1'b0;
    end else begin
      port_clock_q <= port_clock;
    end
  end

  // shift has priority over load in the same cycle
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_chain <= '0;
    end else if (port_clock_fall) begin
      // zeros fill in from the top after the report ends
      shift_chain <= {1'b0, shift_chain[23:1]};
    end else if (latch) begin
      shift_chain <= report;
    end
  end

  // straight from the chain, no output register
  assign serial_data = shift_chain[0];

endmodule

/* hdl/nes_io_frontend.sv */
`timescale 1ns/1ps

module nes_io_frontend (
  input  logic                       clk_ppu_21_47,
  input  logic                       reset_nes,

  // core side of the controller ports
  input  logic                       joypad_latch,
  input  logic [1:0]                 joypad_clock,
  output logic                       joypad1_data,
  output logic                       joypad2_data,

  // player buttons and port options
  input  nes_io_pkg::button_byte_t   p1_buttons,
  input  nes_io_pkg::button_byte_t   p2_buttons,
  input  nes_io_pkg::button_byte_t   p3_buttons,
  input  nes_io_pkg::button_byte_t   p4_buttons,
  input  logic                       multitap_enabled,
  input  logic                       swap_controllers,

  // physical controller on port 1
  output logic                       p1_latch,
  output logic                       p1_clk,
  input  logic                       p1_data,

  // downloader
  input  logic                       ioctl_wr,
  input  nes_io_pkg::ioctl_addr_t    ioctl_addr,
  input  nes_io_pkg::ioctl_byte_t    ioctl_dout,
  input  logic                       palette_download,
  input  logic                       downloading,

  // palette to the video stage
  output logic                       pal_write,
  output nes_io_pkg::rgb_color_t     pal_color,
  output nes_io_pkg::palette_index_t pal_index,

  // reset sources and results
  input  logic                       loader_busy,
  input  logic                       loader_fail,
  input  logic                       hold_reset,
  input  logic                       external_reset,
  output logic                       core_reset,
  output logic                       loader_reset
);

  controller_ports i_controller_ports (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .joypad_latch    (joypad_latch),
    .joypad_clock    (joypad_clock),
    .p1_buttons      (p1_buttons),
    .p2_buttons      (p2_buttons),
    .p3_buttons      (p3_buttons),
    .p4_buttons      (p4_buttons),
    .multitap_enabled(multitap_enabled),
    .swap_controllers(swap_controllers),
    .p1_data         (p1_data),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data),
    .p1_latch        (p1_latch),
    .p1_clk          (p1_clk)
  );

  palette_loader i_palette_loader (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .palette_download(palette_download),
    .ioctl_wr        (ioctl_wr),
    .ioctl_addr      (ioctl_addr),
    .ioctl_dout      (ioctl_dout),
    .pal_write       (pal_write),
    .pal_color       (pal_color),
    .pal_index       (pal_index)
  );

  reset_sequencer i_reset_sequencer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .loader_busy   (loader_busy),
    .loader_fail   (loader_fail),
    .hold_reset    (hold_reset),
    .external_reset(external_reset),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset)
  );

endmodule

/* hdl/nes_io_pkg.sv */
package nes_io_pkg;

  // one player's buttons, bit 0 up to bit 7:
  // A, B, Select, Start, Up, Down, Left, Right
  typedef logic [7:0] button_byte_t;

  // serial report of one port, shifted out LSB first
  // player byte, then extra byte, then signature byte
  typedef logic [23:0] port_shift_t;

  // downloader address and data
  typedef logic [27:0] ioctl_addr_t;
  typedef logic [7:0] ioctl_byte_t;

  // red 23:16, green 15:8, blue 7:0
  typedef logic [23:0] rgb_color_t;

  // 64 palette entries
  typedef logic [5:0] palette_index_t;

  // post-download reset stretch
  typedef logic [7:0] reset_count_t;

  // byte position inside one palette triple
  typedef enum logic [1:0] {
    PHASE_RED,
    PHASE_GREEN,
    PHASE_BLUE
  } pal_phase_t;

  // multitap identification bytes
  localparam button_byte_t PORT1_SIGNATURE = 8'h08;
  localparam button_byte_t PORT2_SIGNATURE = 8'h04;

  // report tail without multitap, reads as all buttons of absent pads
  localparam logic [15:0] NO_EXTRA_PLAYERS = 16'hFFFF;

  // 64 entries of three bytes
  localparam ioctl_addr_t PALETTE_BYTES = 28'd192;

  // idle-loader cycles the core stays in reset after a download
  localparam reset_count_t DOWNLOAD_RESET_CYCLES = 8'd255;

endpackage

/* hdl/palette_loader.sv */
`timescale 1ns/1ps

module palette_loader (
  input  logic                       clk_ppu_21_47,
  input  logic                       reset_nes,
  input  logic                       palette_download,
  input  logic                       ioctl_wr,
  input  nes_io_pkg::ioctl_addr_t    ioctl_addr,
  input  nes_io_pkg::ioctl_byte_t    ioctl_dout,
  output logic                       pal_write,
  output nes_io_pkg::rgb_color_t     pal_color,
  output nes_io_pkg::palette_index_t pal_index
);

  nes_io_pkg::pal_phase_t phase;

  // byte within the palette range of the download
  logic byte_valid;

  assign byte_valid = palette_download && ioctl_wr &&
                      (ioctl_addr < nes_io_pkg::PALETTE_BYTES);

  // phase and entry index
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes || !palette_download) begin
      phase     <= nes_io_pkg::PHASE_RED;
      pal_index <= '0;
    end else if (byte_valid) begin
      case (phase)
        nes_io_pkg::PHASE_RED: begin
          phase <= nes_io_pkg::PHASE_GREEN;
          // first triple stays at entry 0
          if (ioctl_addr != '0) begin
            pal_index <= pal_index + 6'd1;
          end
        end
        nes_io_pkg::PHASE_GREEN: begin
          phase <= nes_io_pkg::PHASE_BLUE;
        end
        default: begin
          phase <= nes_io_pkg::PHASE_RED;
        end
      endcase
    end
  end

  // colour assembly, one byte lane per phase
  always_ff @(posedge clk_ppu_21_47) begin
    if (byte_valid) begin
      case (phase)
        nes_io_pkg::PHASE_RED: begin
          pal_color[23:16] <= ioctl_dout;
        end
        nes_io_pkg::PHASE_GREEN: begin
          pal_color[15:8] <= ioctl_dout;
        end
        default: begin
          pal_color[7:0] <= ioctl_dout;
        end
      endcase
    end
  end

  // back in red means the last triple is complete
  assign pal_write = palette_download && (phase == nes_io_pkg::PHASE_RED);

endmodule

/* hdl/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic downloading,
  input  logic loader_busy,
  input  logic loader_fail,
  input  logic hold_reset,
  input  logic external_reset,
  output logic core_reset,
  output logic loader_reset
);

  // stretch counter, nonzero keeps the core in reset
  nes_io_pkg::reset_count_t download_cnt;
  logic                     download_reset;

  // set once anything has been downloaded
  logic armed;

  // previous downloading level for rise detection
  logic downloading_q;

  assign download_reset = (download_cnt != '0);

  // reload during download, count down while the loader is idle
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      download_cnt <= '0;
    end else if (downloading) begin
      download_cnt <= nes_io_pkg::DOWNLOAD_RESET_CYCLES;
    end else if (download_reset && !loader_busy) begin
      download_cnt <= download_cnt - 8'd1;
    end
  end

  // hold the machine until the first download starts
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      armed <= 1'b0;
    end else if (downloading) begin
      armed <= 1'b1;
    end
  end

  // loader restarts at download start and whenever no stretch runs
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      downloading_q <= 1'b0;
      loader_reset  <= 1'b1;
    end else begin
      downloading_q <= downloading;
      loader_reset  <= !download_reset || (!downloading_q && downloading);
    end
  end

  // any fault or host request also holds the core
  assign core_reset = !armed || download_reset || loader_fail ||
                      hold_reset || external_reset;

endmodule

/* test/tb_nes_io_frontend.sv */
`timescale 1ns/1ps

module tb_nes_io_frontend;

  localparam time CLK_PERIOD     = 40ns;
  localparam int  RESET_CYCLES   = 10;
  localparam int  STRETCH_CYCLES = 255;
  localparam int  BUSY_CYCLES    = 20;

  // rough cycle budget of each test
  localparam int READ_CYCLES      = 2 + 24 * 4;
  localparam int SINGLE_CYCLES    = 2 * (2 * READ_CYCLES + 2 * 8 * 4);
  localparam int MULTITAP_CYCLES  = 4 * READ_CYCLES;
  localparam int RAW_CYCLES       = READ_CYCLES + 10;
  localparam int PALETTE_CYCLES   = 40;
  localparam int RESET_SEQ_CYCLES = 2 * STRETCH_CYCLES + BUSY_CYCLES + 100;
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + SINGLE_CYCLES + MULTITAP_CYCLES +
                                    RAW_CYCLES + PALETTE_CYCLES + RESET_SEQ_CYCLES + 300;

  logic                       clk_ppu_21_47;
  logic                       reset_nes;
  logic                       joypad_latch;
  logic [1:0]                 joypad_clock;
  logic                       joypad1_data;
  logic                       joypad2_data;
  nes_io_pkg::button_byte_t   p1_buttons;
  nes_io_pkg::button_byte_t   p2_buttons;
  nes_io_pkg::button_byte_t   p3_buttons;
  nes_io_pkg::button_byte_t   p4_buttons;
  logic                       multitap_enabled;
  logic                       swap_controllers;
  logic                       p1_latch;
  logic                       p1_clk;
  logic                       p1_data;
  logic                       ioctl_wr;
  nes_io_pkg::ioctl_addr_t    ioctl_addr;
  nes_io_pkg::ioctl_byte_t    ioctl_dout;
  logic                       palette_download;
  logic                       downloading;
  logic                       pal_write;
  nes_io_pkg::rgb_color_t     pal_color;
  nes_io_pkg::palette_index_t pal_index;
  logic                       loader_busy;
  logic                       loader_fail;
  logic                       hold_reset;
  logic                       external_reset;
  logic                       core_reset;
  logic                       loader_reset;

  integer seed = 32'h669d;

  nes_io_frontend i_nes_io_frontend (.*);

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_ppu_21_47);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s: expected %h, got %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // inputs change a little after the edge
  task automatic step();
    @(posedge clk_ppu_21_47);
    #2;
  endtask

  // two cycles per clock level with data taken just before each fall
  task automatic shift_port(input int port, input int count, input logic [23:0] raw_low,
                            output logic [23:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      joypad_clock[port] = 1'b1;
      p1_data = !raw_low[i];
      step();
      step();
      bits[i] = (port == 0) ? joypad1_data : joypad2_data;
      joypad_clock[port] = 1'b0;
      step();
      step();
    end
    p1_data = 1'b1;
  endtask

  task automatic read_port(input int port, input logic [23:0] raw_low,
                           output logic [23:0] bits);
    joypad_latch = 1'b1;
    step();
    joypad_latch = 1'b0;
    step();
    shift_port(port, 24, raw_low, bits);
  endtask

  task automatic write_byte(input nes_io_pkg::ioctl_addr_t addr,
                            input nes_io_pkg::ioctl_byte_t data);
    ioctl_addr = addr;
    ioctl_dout = data;
    ioctl_wr   = 1'b1;
    step();
    ioctl_wr   = 1'b0;
  endtask

  // counts edges until core_reset drops with an optional busy window
  task automatic measure_stretch(input int busy_start, input int busy_len,
                                 output int cycles);
    cycles = 0;
    do begin
      step();
      cycles++;
      if (busy_len > 0 && cycles == busy_start) begin
        loader_busy = 1'b1;
      end
      if (busy_len > 0 && cycles == busy_start + busy_len) begin
        loader_busy = 1'b0;
      end
    end while (core_reset && cycles < 2 * STRETCH_CYCLES);
  endtask

  task automatic single_reports();
    logic [23:0] bits;
    logic [23:0] tail;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    for (int round = 0; round < 2; round++) begin
      p1_buttons = $random(seed);
      p2_buttons = $random(seed);
      p3_buttons = $random(seed);
      p4_buttons = $random(seed);
      read_port(0, '0, bits);
      check_value("joypad1_data report", {16'hFFFF, p1_buttons}, bits);
      shift_port(0, 8, '0, tail);
      check_value("joypad1_data after report", 32'h0, tail);
      read_port(1, '0, bits);
      check_value("joypad2_data report", {16'hFFFF, p2_buttons}, bits);
      shift_port(1, 8, '0, tail);
      check_value("joypad2_data after report", 32'h0, tail);
    end
  endtask

  task automatic multitap_reports();
    logic [23:0] bits;
    multitap_enabled = 1'b1;
    swap_controllers = 1'b0;
    p1_buttons = $random(seed);
    p2_buttons = $random(seed);
    p3_buttons = $random(seed);
    p4_buttons = $random(seed);
    read_port(0, '0, bits);
    check_value("joypad1_data multitap", {8'h08, p3_buttons, p1_buttons}, bits);
    read_port(1, '0, bits);
    check_value("joypad2_data multitap", {8'h04, p4_buttons, p2_buttons}, bits);
    // players 1 and 2 trade ports while the extras stay
    swap_controllers = 1'b1;
    read_port(0, '0, bits);
    check_value("joypad1_data swapped", {8'h08, p3_buttons, p2_buttons}, bits);
    read_port(1, '0, bits);
    check_value("joypad2_data swapped", {8'h04, p4_buttons, p1_buttons}, bits);
    swap_controllers = 1'b0;
  endtask

  task automatic raw_pad_merge();
    logic [23:0] bits;
    logic [23:0] raw_low;
    multitap_enabled = 1'b1;
    swap_controllers = 1'b0;
    p1_buttons = 8'h00;
    p3_buttons = 8'h00;
    raw_low = 24'h42_10_A5;
    read_port(0, raw_low, bits);
    check_value("joypad1_data merged", 24'h08_00_00 | raw_low, bits);
    // physical port follows latch and inverted clock
    joypad_latch    = 1'b1;
    joypad_clock[0] = 1'b0;
    step();
    check_value("p1_latch", 32'h1, p1_latch);
    check_value("p1_clk", 32'h1, p1_clk);
    joypad_latch    = 1'b0;
    joypad_clock[0] = 1'b1;
    step();
    check_value("p1_latch", 32'h0, p1_latch);
    check_value("p1_clk", 32'h0, p1_clk);
    joypad_clock[0] = 1'b0;
    step();
    check_value("p1_clk", 32'h1, p1_clk);
  endtask

  task automatic palette_triples();
    nes_io_pkg::rgb_color_t colors [3];
    palette_download = 1'b1;
    step();
    check_value("pal_write idle", 32'h1, pal_write);
    for (int t = 0; t < 3; t++) begin
      colors[t] = $random(seed);
      write_byte(3 * t, colors[t][23:16]);
      check_value("pal_write mid triple", 32'h0, pal_write);
      write_byte(3 * t + 1, colors[t][15:8]);
      write_byte(3 * t + 2, colors[t][7:0]);
      check_value("pal_color", colors[t], pal_color);
      check_value("pal_index", t, pal_index);
      check_value("pal_write", 32'h1, pal_write);
    end
    // out of the palette range
    write_byte(28'd192, 8'hA5);
    write_byte(28'h0FF_FFFF, 8'h5A);
    check_value("pal_color out of range", colors[2], pal_color);
    check_value("pal_index out of range", 32'h2, pal_index);
    check_value("pal_write out of range", 32'h1, pal_write);
    palette_download = 1'b0;
    step();
    check_value("pal_index after download", 32'h0, pal_index);
    check_value("pal_write after download", 32'h0, pal_write);
  endtask

  task automatic reset_stretch();
    int cycles;
    // machine held while nothing was downloaded
    repeat (3) step();
    check_value("core_reset unarmed", 32'h1, core_reset);
    check_value("loader_reset idle", 32'h1, loader_reset);
    downloading = 1'b1;
    step();
    step();
    check_value("core_reset downloading", 32'h1, core_reset);
    check_value("loader_reset downloading", 32'h0, loader_reset);
    downloading = 1'b0;
    measure_stretch(0, 0, cycles);
    check_value("core_reset stretch cycles", STRETCH_CYCLES, cycles);
    step();
    check_value("core_reset after stretch", 32'h0, core_reset);
    check_value("loader_reset after stretch", 32'h1, loader_reset);

    loader_fail = 1'b1;
    step();
    check_value("core_reset loader_fail", 32'h1, core_reset);
    loader_fail = 1'b0;
    step();
    check_value("core_reset", 32'h0, core_reset);
    external_reset = 1'b1;
    step();
    check_value("core_reset external_reset", 32'h1, core_reset);
    external_reset = 1'b0;
    hold_reset = 1'b1;
    step();
    check_value("core_reset hold_reset", 32'h1, core_reset);
    hold_reset = 1'b0;
    step();
    check_value("core_reset", 32'h0, core_reset);

    // second download starts while a stretch is running
    downloading = 1'b1;
    step();
    step();
    downloading = 1'b0;
    repeat (50) step();
    check_value("loader_reset mid stretch", 32'h0, loader_reset);
    downloading = 1'b1;
    step();
    check_value("loader_reset download rise", 32'h1, loader_reset);
    step();
    check_value("loader_reset download held", 32'h0, loader_reset);
    downloading = 1'b0;
    measure_stretch(100, BUSY_CYCLES, cycles);
    check_value("core_reset busy stretch cycles", STRETCH_CYCLES + BUSY_CYCLES, cycles);
    step();
    check_value("loader_reset after busy stretch", 32'h1, loader_reset);
  endtask

  initial begin
    reset_nes        = 1'b1;
    joypad_latch     = 1'b0;
    joypad_clock     = 2'b00;
    p1_buttons       = 8'h00;
    p2_buttons       = 8'h00;
    p3_buttons       = 8'h00;
    p4_buttons       = 8'h00;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    p1_data          = 1'b1;
    ioctl_wr         = 1'b0;
    ioctl_addr       = '0;
    ioctl_dout       = '0;
    palette_download = 1'b0;
    downloading      = 1'b0;
    loader_busy      = 1'b0;
    loader_fail      = 1'b0;
    hold_reset       = 1'b0;
    external_reset   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_ppu_21_47);
    #2;
    reset_nes = 1'b0;

    single_reports();
    multitap_reports();
    raw_pad_merge();
    palette_triples();
    reset_stretch();

    $display("PASS: all tests");
    $finish;
  end

endmodule
